//--- deci_rx_pkg.sv
/*
 * Shared widths, depths and types of the decimator receive buffers.
 * The sample store, the output FIFO and the top level import it.
 */
`default_nettype none

package deci_rx_pkg;

    // ----------------------------------------------------------
    // sample path
    // ----------------------------------------------------------

    // one audio sample, also one decimated word
    localparam int unsigned SAMPLE_W = 16;

    // pre-decimation store, one window of samples
    localparam int unsigned SAMPLE_RAM_DEPTH = 512;
    localparam int unsigned SAMPLE_ADDR_W    = $clog2(SAMPLE_RAM_DEPTH);

    // ----------------------------------------------------------
    // decimated output FIFO
    // ----------------------------------------------------------

    // default depth, top level may override
    localparam int unsigned DECI_FIFO_DEPTH = 512;

    // one extra bit so a full FIFO can report its whole depth
    localparam int unsigned DECI_LEVEL_W = $clog2(DECI_FIFO_DEPTH) + 1;

    // ----------------------------------------------------------
    // types
    // ----------------------------------------------------------

    typedef logic [SAMPLE_W-1:0]      sample_t;
    typedef logic [SAMPLE_ADDR_W-1:0] sample_addr_t;
    typedef logic [DECI_LEVEL_W-1:0]  deci_level_t;

endpackage

`default_nettype wire

//--- predeci_wr_ctrl.sv
/*
 * Write side of the pre-decimation sample RAM.
 * Counts the sample write address, delays the sample strobe and data
 * by one edge, and hands the RAM write port to the host clear logic
 * while clear mode is on.
 */
`timescale 1ns/1ps
`default_nettype none

module predeci_wr_ctrl
(
    input  wire                            WBs_CLK_i,
    input  wire                            WBs_RST_i,
    // sample source
    input  wire deci_rx_pkg::sample_t      sample_data_i,
    input  wire                            sample_wr_i,
    // host clear port
    input  wire                            clear_mode_i,
    input  wire deci_rx_pkg::sample_addr_t clear_addr_i,
    input  wire                            clear_we_i,
    // RAM write port
    output deci_rx_pkg::sample_addr_t      ram_waddr_o,
    output deci_rx_pkg::sample_t           ram_wdata_o,
    output logic                           ram_we_o,
    // sample side status
    output deci_rx_pkg::sample_addr_t      sample_waddr_o,
    output logic                           sample_we_o
);

    import deci_rx_pkg::*;

    sample_addr_t sample_addr_q;
    logic         sample_we_q;
    sample_t      sample_data_q;

    // ----------------------------------------------------------
    // sample address and write strobe
    // ----------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            // park on the last word, first sample lands at 0
            sample_addr_q <= '1;
            sample_we_q   <= 1'b0;
        end
        else
        begin
            // strobe delayed one edge, lines up with the new address
            sample_we_q <= sample_wr_i;
            if (sample_wr_i)
            begin
                // wraps modulo the RAM depth
                sample_addr_q <= sample_addr_q + sample_addr_t'(1);
            end
        end
    end

    // sample word held until the delayed write
    always_ff @(posedge WBs_CLK_i)
    begin
        if (sample_wr_i)
        begin
            sample_data_q <= sample_data_i;
        end
    end

    // ----------------------------------------------------------
    // write port select
    // ----------------------------------------------------------
    always_comb
    begin
        if (clear_mode_i)
        begin
            // host owns the port, zero fill
            ram_waddr_o = clear_addr_i;
            ram_wdata_o = '0;
            ram_we_o    = clear_we_i;
        end
        else
        begin
            ram_waddr_o = sample_addr_q;
            ram_wdata_o = sample_data_q;
            ram_we_o    = sample_we_q;
        end
    end

    // counter keeps running in clear mode
    assign sample_waddr_o = sample_addr_q;
    assign sample_we_o    = sample_we_q;

    // host may only write while it owns the port
    a_clear_we_in_mode : assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        clear_we_i |-> clear_mode_i
    ) else $error("clear_we_i outside clear mode");

endmodule

`default_nettype wire

//--- predeci_sample_ram.sv
/*
 * Pre-decimation sample RAM, 512 words of 16 bits.
 * One write port from the write control, one registered read port
 * for the FIR decimator with a latency of one cycle.
 * Read during write of the same address returns the old word.
 */
`timescale 1ns/1ps
`default_nettype none

module predeci_sample_ram
(
    input  wire                            WBs_CLK_i,
    // write port
    input  wire deci_rx_pkg::sample_addr_t waddr_i,
    input  wire deci_rx_pkg::sample_t      wdata_i,
    input  wire                            we_i,
    // decimator read port
    input  wire deci_rx_pkg::sample_addr_t raddr_i,
    output deci_rx_pkg::sample_t           rd_data_o
);

    import deci_rx_pkg::*;

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------

    // contents undefined until written, host clears it first
    sample_t mem [SAMPLE_RAM_DEPTH];

    // read data register
    sample_t rd_data_q;

    // write port
    always_ff @(posedge WBs_CLK_i)
    begin
        if (we_i)
        begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // ----------------------------------------------------------
    // read port
    // ----------------------------------------------------------

    // sampled every edge, old word on an address collision
    always_ff @(posedge WBs_CLK_i)
    begin
        rd_data_q <= mem[raddr_i];
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- deci_out_fifo.sv
/*
 * Synchronous FIFO for the decimated output words.
 * First-word fall-through: pop_data_o shows the head word while the
 * FIFO is not empty. A push when full or a pop when empty is dropped.
 * Flush clears pointers and level at the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

module deci_out_fifo
#(
    // must be a power of two
    parameter int unsigned FIFO_DEPTH = deci_rx_pkg::DECI_FIFO_DEPTH
)
(
    input  wire                       WBs_CLK_i,
    input  wire                       WBs_RST_i,
    input  wire                       flush_i,
    // producer side
    input  wire                       push_i,
    input  wire deci_rx_pkg::sample_t push_data_i,
    // consumer side
    input  wire                       pop_i,
    output deci_rx_pkg::sample_t      pop_data_o,
    // status
    output logic                      empty_o,
    output logic                      full_o,
    output deci_rx_pkg::deci_level_t  level_o
);

    import deci_rx_pkg::*;

    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    // level reported when every slot holds a word
    localparam deci_level_t LEVEL_FULL = deci_level_t'(FIFO_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    sample_t     mem [FIFO_DEPTH];
    ptr_t        wr_ptr_q;
    ptr_t        rd_ptr_q;
    deci_level_t level_q;
    deci_level_t level_d;
    logic        push_ok;
    logic        pop_ok;

    // ----------------------------------------------------------
    // accept logic
    // ----------------------------------------------------------

    // flush wins over both strobes
    assign push_ok = push_i & ~full_o & ~flush_i;
    assign pop_ok  = pop_i & ~empty_o & ~flush_i;

    // ----------------------------------------------------------
    // storage and pointers
    // ----------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        if (push_ok)
        begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else if (flush_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr_q <= wr_ptr_q + ptr_t'(1);
            end
            if (pop_ok)
            begin
                rd_ptr_q <= rd_ptr_q + ptr_t'(1);
            end
        end
    end

    // ----------------------------------------------------------
    // level counter
    // ----------------------------------------------------------

    // hold, add or subtract one word per edge
    always_comb
    begin
        level_d = level_q;
        if (flush_i)
        begin
            level_d = '0;
        end
        else
        begin
            case ({pop_ok, push_ok})
                2'b01:   level_d = level_q + deci_level_t'(1);
                2'b10:   level_d = level_q - deci_level_t'(1);
                // idle, or push and pop together
                default: level_d = level_q;
            endcase
        end
    end

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            level_q <= '0;
        end
        else
        begin
            level_q <= level_d;
        end
    end

    // ----------------------------------------------------------
    // outputs
    // ----------------------------------------------------------

    // head word, valid while not empty
    assign pop_data_o = mem[rd_ptr_q];

    assign empty_o = (level_q == '0);
    assign full_o  = (level_q == LEVEL_FULL);
    assign level_o = level_q;

    // occupancy never above the depth
    a_level_max : assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        level_q <= LEVEL_FULL
    ) else $error("FIFO level above depth");

    // level agrees with the pointer distance modulo the depth
    a_level_ptr : assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
        ptr_t'(wr_ptr_q - rd_ptr_q) == level_q[PTR_W-1:0]
    ) else $error("FIFO level out of step with pointers");

endmodule

`default_nettype wire

//--- deci_rx_buffers.sv
/*
 * Receive buffers around the FIR decimator.
 * Audio samples go into the pre-decimation RAM, the decimator reads
 * them back through its own address port, and its output words are
 * queued in the output FIFO. A host can zero the RAM in clear mode.
 */
`timescale 1ns/1ps
`default_nettype none

module deci_rx_buffers
#(
    parameter int unsigned FIFO_DEPTH = deci_rx_pkg::DECI_FIFO_DEPTH
)
(
    input  wire                            WBs_CLK_i,
    input  wire                            WBs_RST_i,
    // sample path
    input  wire deci_rx_pkg::sample_t      sample_data_i,
    input  wire                            sample_wr_i,
    output deci_rx_pkg::sample_addr_t      sample_waddr_o,
    output logic                           sample_we_o,
    // clear mode
    input  wire                            clear_mode_i,
    input  wire deci_rx_pkg::sample_addr_t clear_addr_i,
    input  wire                            clear_we_i,
    // decimator read
    input  wire deci_rx_pkg::sample_addr_t fir_raddr_i,
    output deci_rx_pkg::sample_t           fir_rd_data_o,
    // output FIFO
    input  wire deci_rx_pkg::sample_t      deci_data_i,
    input  wire                            deci_push_i,
    input  wire                            deci_flush_i,
    input  wire                            deci_pop_i,
    output deci_rx_pkg::sample_t           deci_data_o,
    output logic                           deci_empty_o,
    output logic                           deci_full_o,
    output deci_rx_pkg::deci_level_t       deci_level_o
);

    import deci_rx_pkg::*;

    // RAM write port after the sample/clear select
    sample_addr_t ram_waddr;
    sample_t      ram_wdata;
    logic         ram_we;

    // ----------------------------------------------------------
    // pre-decimation sample store
    // ----------------------------------------------------------
    predeci_wr_ctrl u_wr_ctrl
    (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .sample_data_i  (sample_data_i),
        .sample_wr_i    (sample_wr_i),
        .clear_mode_i   (clear_mode_i),
        .clear_addr_i   (clear_addr_i),
        .clear_we_i     (clear_we_i),
        .ram_waddr_o    (ram_waddr),
        .ram_wdata_o    (ram_wdata),
        .ram_we_o       (ram_we),
        .sample_waddr_o (sample_waddr_o),
        .sample_we_o    (sample_we_o)
    );

    // decimator reads through its own port
    predeci_sample_ram u_sample_ram
    (
        .WBs_CLK_i (WBs_CLK_i),
        .waddr_i   (ram_waddr),
        .wdata_i   (ram_wdata),
        .we_i      (ram_we),
        .raddr_i   (fir_raddr_i),
        .rd_data_o (fir_rd_data_o)
    );

    // ----------------------------------------------------------
    // decimated output FIFO
    // ----------------------------------------------------------
    deci_out_fifo
    #(
        .FIFO_DEPTH (FIFO_DEPTH)
    )
    u_out_fifo
    (
        .WBs_CLK_i   (WBs_CLK_i),
        .WBs_RST_i   (WBs_RST_i),
        .flush_i     (deci_flush_i),
        .push_i      (deci_push_i),
        .push_data_i (deci_data_i),
        .pop_i       (deci_pop_i),
        .pop_data_o  (deci_data_o),
        .empty_o     (deci_empty_o),
        .full_o      (deci_full_o),
        .level_o     (deci_level_o)
    );

endmodule

`default_nettype wire

//--- tb_deci_rx_buffers.sv
/*
 * Self-checking testbench for the decimator receive buffers.
 * A RAM array and a FIFO queue act as reference models. Stimulus is
 * driven on the falling edge, and the FIFO status is compared on every
 * falling edge by its own process. Run it through src.f.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_deci_rx_buffers;

    import deci_rx_pkg::*;

    localparam int FIFO_DEPTH = 512;
    // cycle budget of reset and of tests 1 to 6
    localparam int CYCLE_BUDGET = 10 + 10 + 2400 + 1300 + 3100 + 1100 + 300;

    logic         clk = 1'b0;
    logic         rst;
    sample_t      sample_data_i;
    logic         sample_wr_i;
    sample_addr_t sample_waddr_o;
    logic         sample_we_o;
    logic         clear_mode_i;
    sample_addr_t clear_addr_i;
    logic         clear_we_i;
    sample_addr_t fir_raddr_i;
    sample_t      fir_rd_data_o;
    sample_t      deci_data_i;
    logic         deci_push_i;
    logic         deci_flush_i;
    logic         deci_pop_i;
    sample_t      deci_data_o;
    logic         deci_empty_o;
    logic         deci_full_o;
    deci_level_t  deci_level_o;

    // reference models
    sample_t      ram_model [SAMPLE_RAM_DEPTH];
    sample_t      fifo_q [$];
    sample_addr_t exp_waddr;
    logic         pend_v;
    sample_addr_t pend_a;
    sample_t      pend_d;

    int   errors = 0;
    int   tests_ok = 0;
    int   tests_bad = 0;
    logic fifo_chk = 1'b0;

    deci_rx_buffers #(.FIFO_DEPTH(FIFO_DEPTH)) u_dut
    (
        .WBs_CLK_i      (clk),
        .WBs_RST_i      (rst),
        .sample_data_i  (sample_data_i),
        .sample_wr_i    (sample_wr_i),
        .sample_waddr_o (sample_waddr_o),
        .sample_we_o    (sample_we_o),
        .clear_mode_i   (clear_mode_i),
        .clear_addr_i   (clear_addr_i),
        .clear_we_i     (clear_we_i),
        .fir_raddr_i    (fir_raddr_i),
        .fir_rd_data_o  (fir_rd_data_o),
        .deci_data_i    (deci_data_i),
        .deci_push_i    (deci_push_i),
        .deci_flush_i   (deci_flush_i),
        .deci_pop_i     (deci_pop_i),
        .deci_data_o    (deci_data_o),
        .deci_empty_o   (deci_empty_o),
        .deci_full_o    (deci_full_o),
        .deci_level_o   (deci_level_o)
    );

    always #10 clk = ~clk;

    // ----------------------------------------------------------
    // reference functions and checks
    // ----------------------------------------------------------
    function automatic sample_t exp_read(input sample_addr_t a);
        return ram_model[a];
    endfunction

    function automatic deci_level_t exp_level();
        return deci_level_t'(fifo_q.size());
    endfunction

    task automatic compare(input logic [31:0] act, input logic [31:0] exp, input string msg);
        if (act !== exp)
        begin
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, msg, act, exp);
            errors++;
        end
    endtask

    // FIFO status after every edge
    always @(negedge clk)
    begin
        if (fifo_chk)
        begin
            compare(32'(deci_level_o), 32'(exp_level()), "fifo level");
            compare(32'(deci_empty_o), 32'(fifo_q.size() == 0), "fifo empty");
            compare(32'(deci_full_o), 32'(fifo_q.size() == FIFO_DEPTH), "fifo full");
            if (fifo_q.size() > 0)
                compare(32'(deci_data_o), 32'(fifo_q[0]), "fifo head word");
        end
    end

    // ----------------------------------------------------------
    // stimulus tasks
    // ----------------------------------------------------------

    // one RAM write side cycle with the model write of its closing edge
    task automatic ram_cycle(input logic sw, input sample_t sd, input logic cm,
                             input logic cwe, input sample_addr_t ca);
        @(negedge clk);
        compare(32'(sample_waddr_o), 32'(exp_waddr), "sample write address");
        compare(32'(sample_we_o), 32'(pend_v), "sample write strobe");
        sample_wr_i   = sw;
        sample_data_i = sd;
        clear_mode_i  = cm;
        clear_we_i    = cwe;
        clear_addr_i  = ca;
        // delayed sample write is lost while the host owns the port
        if (cm)
        begin
            if (cwe)
                ram_model[ca] = '0;
        end
        else if (pend_v)
            ram_model[pend_a] = pend_d;
        pend_v = sw;
        if (sw)
        begin
            exp_waddr = exp_waddr + 9'd1;
            pend_a    = exp_waddr;
            pend_d    = sd;
        end
    endtask

    // one cycle read latency
    task automatic read_back(input int a);
        @(negedge clk);
        fir_raddr_i = sample_addr_t'(a);
        @(negedge clk);
        compare(32'(fir_rd_data_o), 32'(exp_read(sample_addr_t'(a))),
                $sformatf("ram word %0d", a));
    endtask

    task automatic read_all();
        ram_cycle(1'b0, '0, 1'b0, 1'b0, '0);
        ram_cycle(1'b0, '0, 1'b0, 1'b0, '0);
        for (int a = 0; a < SAMPLE_RAM_DEPTH; a++)
            read_back(a);
    endtask

    task automatic fifo_cycle(input logic push, input logic pop, input logic flush,
                              input sample_t d);
        logic push_ok;
        logic pop_ok;
        @(negedge clk);
        deci_push_i  = push;
        deci_pop_i   = pop;
        deci_flush_i = flush;
        deci_data_i  = d;
        push_ok = push && !flush && (fifo_q.size() < FIFO_DEPTH);
        pop_ok  = pop && !flush && (fifo_q.size() > 0);
        @(posedge clk);
        if (flush)
            fifo_q.delete();
        else
        begin
            if (pop_ok)
                void'(fifo_q.pop_front());
            if (push_ok)
                fifo_q.push_back(d);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before)
        begin
            tests_ok++;
            $display("test %s: ok", name);
        end
        else
        begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    initial
    begin
        int e;
        void'($urandom(32'hac4b_801c));
        rst           = 1'b1;
        sample_wr_i   = 1'b0;
        clear_mode_i  = 1'b0;
        clear_we_i    = 1'b0;
        deci_push_i   = 1'b0;
        deci_pop_i    = 1'b0;
        deci_flush_i  = 1'b0;
        sample_data_i = '0;
        clear_addr_i  = '0;
        fir_raddr_i   = '0;
        deci_data_i   = '0;
        exp_waddr     = '1;
        pend_v        = 1'b0;
        pend_a        = '0;
        pend_d        = '0;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // reset state
        e = errors;
        compare(32'(deci_empty_o), 32'd1, "empty after reset");
        compare(32'(deci_full_o), 32'd0, "full after reset");
        compare(32'(deci_level_o), 32'd0, "level after reset");
        compare(32'(sample_waddr_o), 32'd511, "sample address after reset");
        compare(32'(sample_we_o), 32'd0, "sample strobe after reset");
        @(posedge clk);
        fifo_chk = 1'b1;
        finish_test("reset state", e);

        // clear the RAM then store samples with gaps past the wrap
        e = errors;
        for (int a = 0; a < SAMPLE_RAM_DEPTH; a++)
            ram_cycle(1'b0, '0, 1'b1, 1'b1, sample_addr_t'(a));
        ram_cycle(1'b0, '0, 1'b0, 1'b0, '0);
        for (int k = 0; k < 600; k++)
        begin
            ram_cycle(1'b1, 16'($urandom), 1'b0, 1'b0, '0);
            if ($urandom % 3 == 0)
                ram_cycle(1'b0, '0, 1'b0, 1'b0, '0);
        end
        read_all();
        finish_test("sample store", e);

        // zero writes while samples keep arriving
        e = errors;
        for (int k = 0; k < 200; k++)
            ram_cycle(1'($urandom), 16'($urandom), 1'b1, 1'($urandom), 9'($urandom));
        read_all();
        finish_test("clear mode", e);

        // random push and pop with a filling then a draining bias
        e = errors;
        for (int k = 0; k < 3000; k++)
        begin
            if (k < 1500)
                fifo_cycle(1'($urandom % 3 != 0), 1'($urandom), 1'b0, 16'($urandom));
            else
                fifo_cycle(1'($urandom), 1'($urandom % 3 != 0), 1'b0, 16'($urandom));
        end
        fifo_cycle(1'b0, 1'b0, 1'b0, '0);
        finish_test("fifo order and level", e);

        // full and empty limits
        e = errors;
        while (fifo_q.size() < FIFO_DEPTH)
            fifo_cycle(1'b1, 1'b0, 1'b0, 16'($urandom));
        fifo_cycle(1'b0, 1'b0, 1'b0, '0);
        @(negedge clk);
        compare(32'(deci_full_o), 32'd1, "full at depth");
        fifo_cycle(1'b1, 1'b0, 1'b0, 16'hdead);
        while (fifo_q.size() > 0)
            fifo_cycle(1'b0, 1'b1, 1'b0, '0);
        fifo_cycle(1'b0, 1'b1, 1'b0, '0);
        fifo_cycle(1'b0, 1'b0, 1'b0, '0);
        @(negedge clk);
        compare(32'(deci_level_o), 32'd0, "level after extra pop");
        finish_test("full and empty limits", e);

        // flush with a push in the same cycle
        e = errors;
        repeat (100) fifo_cycle(1'b1, 1'b0, 1'b0, 16'($urandom));
        repeat (30) fifo_cycle(1'b0, 1'b1, 1'b0, '0);
        fifo_cycle(1'b1, 1'b0, 1'b1, 16'hbeef);
        fifo_cycle(1'b0, 1'b0, 1'b0, '0);
        @(negedge clk);
        compare(32'(deci_empty_o), 32'd1, "empty after flush");
        repeat (40) fifo_cycle(1'b1, 1'($urandom), 1'b0, 16'($urandom));
        while (fifo_q.size() > 0)
            fifo_cycle(1'b0, 1'b1, 1'b0, '0);
        fifo_cycle(1'b0, 1'b0, 1'b0, '0);
        finish_test("flush", e);

        $display("tests passed %0d, tests failed %0d, failed checks %0d",
                 tests_ok, tests_bad, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog over the budget plus a margin of 1000 cycles
    initial
    begin
        #((CYCLE_BUDGET + 1000) * 20);
        $display("watchdog timeout, the tests did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
deci_rx_pkg.sv
predeci_wr_ctrl.sv
predeci_sample_ram.sv
deci_out_fifo.sv
deci_rx_buffers.sv
tb_deci_rx_buffers.sv

//--- Makefile
# Verilator build and run of the decimator receive buffers testbench

TOP := tb_deci_rx_buffers
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
